// File: rtl/trigger_config.svh
`ifndef TRIGGER_CONFIG_SVH
`define TRIGGER_CONFIG_SVH

// slow level inputs
`define TRIG_LEVEL_LANES 4

// level lanes plus the one asynchronous strobe channel
`define TRIG_CHANNELS 5

// sampling shift register length, at least 3
`define TRIG_EDGE_DEPTH 3

// per-channel event counter width
`define TRIG_COUNT_WIDTH 16

// free-running timestamp width, in clock cycles
`define TRIG_TIME_WIDTH 32

// cycles spent in holdoff after each trigger
`define TRIG_HOLDOFF_CYCLES 8

`endif

// File: rtl/trigger_pkg.sv
`include "trigger_config.svh"

package trigger_pkg;

	// one bit per channel, strobe channel on top
	typedef logic [`TRIG_CHANNELS-1:0] channel_t;

	// one bit per level lane
	typedef logic [`TRIG_LEVEL_LANES-1:0] level_t;

	typedef logic [`TRIG_COUNT_WIDTH-1:0] count_t;

	// time in clock cycles since reset
	typedef logic [`TRIG_TIME_WIDTH-1:0] timestamp_t;

	// channel select for the count readout
	typedef logic [$clog2(`TRIG_CHANNELS)-1:0] channel_index_t;

	// wide enough to hold the holdoff length
	typedef logic [$clog2(`TRIG_HOLDOFF_CYCLES):0] holdoff_t;

	typedef enum logic [1:0] {
		trig_idle,
		trig_armed,
		trig_holdoff
	} trigger_state_t;

endpackage

// File: rtl/edge_to_pulse.sv
`timescale 1ns/1ps
`include "trigger_config.svh"

module edge_to_pulse (
	input logic clock,
	input logic randy,
	input trigger_pkg::level_t level_in,
	output trigger_pkg::level_t level_pulse
);
	localparam int depth = `TRIG_EDGE_DEPTH;
	localparam int lanes = `TRIG_LEVEL_LANES;

	// sample history per lane, bit 0 is the newest
	logic [depth-1:0] history [lanes];

	// front stages double as the synchronizer
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			for (int lane = 0; lane < lanes; lane++) begin
				history[lane] <= '0;
			end
		end else begin
			for (int lane = 0; lane < lanes; lane++) begin
				history[lane] <= {history[lane][depth-2:0], level_in[lane]};
			end
		end
	end

	// low then high in the two oldest stages marks a rising edge
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			level_pulse <= '0;
		end else begin
			for (int lane = 0; lane < lanes; lane++) begin
				level_pulse[lane] <= (history[lane][depth-1:depth-2] == 2'b01);
			end
		end
	end

endmodule

// File: rtl/pulse_catcher.sv
`timescale 1ns/1ps

module pulse_catcher (
	input logic clock,
	input logic randy,
	input logic strobe_in,
	output logic strobe_pulse
);
	// set by the strobe edge itself, no clock involved
	logic captured;
	logic capture_clear;
	// two stages into the clock domain
	logic sync_meta;
	logic sync_level;
	// previous value of the stretched level
	logic sync_level_d;

	// release once the level has crossed and the strobe is gone
	assign capture_clear = randy | (sync_level & ~strobe_in);

	always_ff @(posedge strobe_in or posedge capture_clear) begin
		if (capture_clear) begin
			captured <= 1'b0;
		end else begin
			captured <= 1'b1;
		end
	end

	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			sync_meta <= 1'b0;
			sync_level <= 1'b0;
		end else begin
			sync_meta <= captured;
			sync_level <= sync_meta;
		end
	end

	// single pulse on the rise of the stretched level
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			sync_level_d <= 1'b0;
			strobe_pulse <= 1'b0;
		end else begin
			sync_level_d <= sync_level;
			strobe_pulse <= sync_level & ~sync_level_d;
		end
	end

endmodule

// File: rtl/event_counters.sv
`timescale 1ns/1ps
`include "trigger_config.svh"

module event_counters (
	input logic clock,
	input logic randy,
	input trigger_pkg::channel_t channel_pulse,
	input logic clear_counts,
	input trigger_pkg::channel_index_t count_select,
	output trigger_pkg::count_t count_value
);
	localparam int channels = `TRIG_CHANNELS;

	trigger_pkg::count_t counts [channels];

	// counters wrap, clear beats a pulse in the same cycle
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			for (int ch = 0; ch < channels; ch++) begin
				counts[ch] <= '0;
			end
		end else if (clear_counts) begin
			for (int ch = 0; ch < channels; ch++) begin
				counts[ch] <= '0;
			end
		end else begin
			for (int ch = 0; ch < channels; ch++) begin
				if (channel_pulse[ch]) begin
					counts[ch] <= counts[ch] + 1'b1;
				end
			end
		end
	end

	// registered readout, unused select codes read as zero
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			count_value <= '0;
		end else if (int'(count_select) < channels) begin
			count_value <= counts[count_select];
		end else begin
			count_value <= '0;
		end
	end

endmodule

// File: rtl/timestamp_capture.sv
`timescale 1ns/1ps

module timestamp_capture (
	input logic clock,
	input logic randy,
	input logic fire,
	output trigger_pkg::timestamp_t trigger_time
);
	// zero in the first cycle after reset
	trigger_pkg::timestamp_t time_count;

	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			time_count <= '0;
		end else begin
			time_count <= time_count + 1'b1;
		end
	end

	// holds the time of the firing cycle until the next fire
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			trigger_time <= '0;
		end else if (fire) begin
			trigger_time <= time_count;
		end
	end

endmodule

// File: rtl/trigger_control.sv
`timescale 1ns/1ps
`include "trigger_config.svh"

module trigger_control (
	input logic clock,
	input logic randy,
	input trigger_pkg::channel_t channel_pulse,
	input trigger_pkg::channel_t enable_mask,
	input logic arm,
	input logic continuous,
	output logic trigger,
	output logic busy,
	output trigger_pkg::channel_t hit_pattern
);
	localparam trigger_pkg::holdoff_t holdoff_last =
		trigger_pkg::holdoff_t'(`TRIG_HOLDOFF_CYCLES - 1);

	trigger_pkg::trigger_state_t state;
	trigger_pkg::holdoff_t holdoff_count;
	trigger_pkg::channel_t masked_pulse;

	assign masked_pulse = channel_pulse & enable_mask;
	assign busy = (state != trigger_pkg::trig_idle);

	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			state <= trigger_pkg::trig_idle;
			holdoff_count <= '0;
			trigger <= 1'b0;
			hit_pattern <= '0;
		end else begin
			trigger <= 1'b0;
			case (state)
				trigger_pkg::trig_idle: begin
					if (arm) begin
						state <= trigger_pkg::trig_armed;
					end
				end
				trigger_pkg::trig_armed: begin
					// fire on any enabled channel
					if (|masked_pulse) begin
						trigger <= 1'b1;
						hit_pattern <= masked_pulse;
						holdoff_count <= holdoff_last;
						state <= trigger_pkg::trig_holdoff;
					end
				end
				trigger_pkg::trig_holdoff: begin
					// the firing cycle is the first holdoff cycle
					if (holdoff_count == '0) begin
						if (continuous) begin
							state <= trigger_pkg::trig_armed;
						end else begin
							state <= trigger_pkg::trig_idle;
						end
					end else begin
						holdoff_count <= holdoff_count - 1'b1;
					end
				end
				default: begin
					state <= trigger_pkg::trig_idle;
				end
			endcase
		end
	end

endmodule

// File: rtl/trigger_front_end.sv
`timescale 1ns/1ps

module trigger_front_end (
	input logic clock,
	input logic randy,
	input trigger_pkg::level_t level_in,
	input logic strobe_in,
	input logic arm,
	input logic continuous,
	input trigger_pkg::channel_t enable_mask,
	input logic clear_counts,
	input trigger_pkg::channel_index_t count_select,
	output logic trigger,
	output logic busy,
	output trigger_pkg::channel_t hit_pattern,
	output trigger_pkg::timestamp_t trigger_time,
	output trigger_pkg::count_t count_value
);
	trigger_pkg::level_t level_pulse;
	logic strobe_pulse;
	trigger_pkg::channel_t channel_pulse;
	logic fire;

	// strobe channel sits above the level lanes
	assign channel_pulse = {strobe_pulse, level_pulse};
	assign trigger = fire;

	edge_to_pulse u_edge_to_pulse (
		.clock(clock),
		.randy(randy),
		.level_in(level_in),
		.level_pulse(level_pulse)
	);

	pulse_catcher u_pulse_catcher (
		.clock(clock),
		.randy(randy),
		.strobe_in(strobe_in),
		.strobe_pulse(strobe_pulse)
	);

	event_counters u_event_counters (
		.clock(clock),
		.randy(randy),
		.channel_pulse(channel_pulse),
		.clear_counts(clear_counts),
		.count_select(count_select),
		.count_value(count_value)
	);

	timestamp_capture u_timestamp_capture (
		.clock(clock),
		.randy(randy),
		.fire(fire),
		.trigger_time(trigger_time)
	);

	trigger_control u_trigger_control (
		.clock(clock),
		.randy(randy),
		.channel_pulse(channel_pulse),
		.enable_mask(enable_mask),
		.arm(arm),
		.continuous(continuous),
		.trigger(fire),
		.busy(busy),
		.hit_pattern(hit_pattern)
	);

endmodule

// File: sim/trigger_front_end_asserts.sv
`timescale 1ns/1ps
`include "trigger_config.svh"

module trigger_front_end_asserts (
	input logic clock,
	input logic randy,
	input logic trigger,
	input logic busy,
	input trigger_pkg::channel_t hit_pattern,
	input trigger_pkg::channel_t enable_mask
);
	// read by the testbench at the end of the run
	int assert_failures = 0;

	trigger_one_cycle: assert property (@(posedge clock) disable iff (randy)
		trigger |=> !trigger)
	else begin
		$error("trigger held for more than one cycle");
		assert_failures++;
	end

	trigger_while_busy: assert property (@(posedge clock) disable iff (randy)
		trigger |-> busy)
	else begin
		$error("trigger seen while not busy");
		assert_failures++;
	end

	// the firing cycle opens the holdoff window
	trigger_holdoff_gap: assert property (@(posedge clock) disable iff (randy)
		trigger |=> !trigger [*`TRIG_HOLDOFF_CYCLES])
	else begin
		$error("trigger repeated inside holdoff");
		assert_failures++;
	end

	hit_within_mask: assert property (@(posedge clock) disable iff (randy)
		trigger |-> ((hit_pattern & ~enable_mask) == '0))
	else begin
		$error("hit pattern outside enable mask");
		assert_failures++;
	end

endmodule

// File: sim/trigger_front_end_tb.sv
`timescale 1ns/1ps
`include "trigger_config.svh"

module trigger_front_end_tb;
	localparam int lanes = `TRIG_LEVEL_LANES;
	localparam int channels = `TRIG_CHANNELS;
	// run limit far above the summed test lengths
	localparam int timeout_cycles = 2000;

	logic clock;
	logic randy;
	trigger_pkg::level_t level_in;
	logic strobe_in;
	logic arm;
	logic continuous;
	trigger_pkg::channel_t enable_mask;
	logic clear_counts;
	trigger_pkg::channel_index_t count_select;
	logic trigger;
	logic busy;
	trigger_pkg::channel_t hit_pattern;
	trigger_pkg::timestamp_t trigger_time;
	trigger_pkg::count_t count_value;

	// reference model state
	trigger_pkg::count_t expected_counts [channels];
	int cycle_count = 0;
	int test_errors = 0;
	int pass_count = 0;
	int fail_count = 0;

	trigger_front_end DUT (.*);

	bind trigger_front_end trigger_front_end_asserts u_asserts (
		.clock(clock),
		.randy(randy),
		.trigger(trigger),
		.busy(busy),
		.hit_pattern(hit_pattern),
		.enable_mask(enable_mask)
	);

	always #4 clock = ~clock;

	// edges since reset release track the DUT time count
	always @(posedge clock) begin
		if (!randy) begin
			cycle_count++;
		end
		if (cycle_count >= timeout_cycles) begin
			$display("timeout after %0d cycles, a test never finished", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic compare_count(input string name, input trigger_pkg::count_t expected,
			input trigger_pkg::count_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic compare_channels(input string name, input trigger_pkg::channel_t expected,
			input trigger_pkg::channel_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %b actual %b", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic compare_time(input string name, input trigger_pkg::timestamp_t expected,
			input trigger_pkg::timestamp_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %b actual %b", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("PASS %s", name);
		end else begin
			fail_count++;
			$display("FAIL %s with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// a rising level adds one expected event on its lane
	task automatic drive_lane(input int lane, input logic value);
		if (value && !level_in[lane]) begin
			expected_counts[lane] = expected_counts[lane] + 1'b1;
		end
		level_in[lane] = value;
	endtask

	// readout is registered, so the value shows one edge after the select
	task automatic check_all_counts(input string name);
		for (int ch = 0; ch < channels; ch++) begin
			count_select = trigger_pkg::channel_index_t'(ch);
			next_cycle();
			compare_count($sformatf("%s ch%0d", name, ch), expected_counts[ch], count_value);
		end
	endtask

	task automatic watch_no_trigger(input string name, input int cycles);
		for (int i = 0; i < cycles; i++) begin
			next_cycle();
			if (trigger) begin
				$display("%s: trigger fired where none was expected", name);
				test_errors++;
			end
		end
	endtask

	task automatic wait_for_trigger(input string name, input int limit, output int fired_at);
		fired_at = -1;
		for (int i = 0; i < limit && fired_at < 0; i++) begin
			next_cycle();
			if (trigger) begin
				fired_at = cycle_count;
			end
		end
		if (fired_at < 0) begin
			$display("%s: no trigger within %0d cycles", name, limit);
			test_errors++;
		end
	endtask

	task automatic wait_busy_low(input string name, input int limit);
		int waited;
		waited = 0;
		while (busy && waited < limit) begin
			next_cycle();
			waited++;
		end
		if (busy) begin
			$display("%s: busy stayed high for %0d cycles", name, limit);
			test_errors++;
		end
	endtask

	task automatic test_reset_state();
		compare_bit("reset trigger", 1'b0, trigger);
		compare_bit("reset busy", 1'b0, busy);
		compare_channels("reset hit", '0, hit_pattern);
		compare_time("reset time", '0, trigger_time);
		check_all_counts("reset");
		finish_test("reset_state");
	endtask

	task automatic test_level_edges();
		int lane;
		int gap;
		for (int round = 0; round < 12; round++) begin
			lane = $urandom % lanes;
			drive_lane(lane, !level_in[lane]);
			gap = 2 + $urandom % 6;
			repeat (gap) next_cycle();
		end
		// long hold on whatever is still high
		repeat (10) next_cycle();
		check_all_counts("level_edges held");
		for (int l = 0; l < lanes; l++) begin
			drive_lane(l, 1'b0);
		end
		repeat (4) next_cycle();
		check_all_counts("level_edges dropped");
		finish_test("level_edges");
	endtask

	task automatic test_narrow_strobes();
		int gap;
		for (int n = 0; n < 3; n++) begin
			strobe_in = 1'b1;
			#2;
			strobe_in = 1'b0;
			expected_counts[channels-1] = expected_counts[channels-1] + 1'b1;
			gap = 10 + $urandom % 5;
			repeat (gap) next_cycle();
		end
		check_all_counts("narrow_strobes");
		finish_test("narrow_strobes");
	endtask

	task automatic test_single_trigger();
		string name;
		int hit_lane;
		int other_lane;
		int fired_at;
		trigger_pkg::channel_t hit_bits;
		name = "single_trigger";
		hit_lane = $urandom % lanes;
		other_lane = (hit_lane + 1 + $urandom % (lanes - 1)) % lanes;
		hit_bits = '0;
		hit_bits[hit_lane] = 1'b1;
		enable_mask = hit_bits;
		continuous = 1'b0;
		arm = 1'b1;
		next_cycle();
		arm = 1'b0;
		next_cycle();
		compare_bit({name, " busy armed"}, 1'b1, busy);
		// disabled lane is counted but must not fire
		drive_lane(other_lane, 1'b1);
		watch_no_trigger(name, 8);
		drive_lane(other_lane, 1'b0);
		drive_lane(hit_lane, 1'b1);
		wait_for_trigger(name, 8, fired_at);
		compare_bit({name, " busy at trigger"}, 1'b1, busy);
		compare_channels({name, " hit"}, hit_bits, hit_pattern);
		next_cycle();
		compare_bit({name, " trigger width"}, 1'b0, trigger);
		compare_time({name, " time"}, trigger_pkg::timestamp_t'(fired_at), trigger_time);
		drive_lane(hit_lane, 1'b0);
		wait_busy_low(name, 16);
		check_all_counts(name);
		finish_test(name);
	endtask

	task automatic test_continuous_mode();
		string name;
		int lane;
		int fired_at;
		name = "continuous_mode";
		lane = $urandom % lanes;
		enable_mask = '0;
		enable_mask[lane] = 1'b1;
		continuous = 1'b1;
		arm = 1'b1;
		next_cycle();
		arm = 1'b0;
		drive_lane(lane, 1'b1);
		wait_for_trigger(name, 8, fired_at);
		// second edge lands inside holdoff
		drive_lane(lane, 1'b0);
		next_cycle();
		drive_lane(lane, 1'b1);
		watch_no_trigger(name, 6);
		compare_bit({name, " busy holdoff"}, 1'b1, busy);
		drive_lane(lane, 1'b0);
		next_cycle();
		drive_lane(lane, 1'b1);
		wait_for_trigger(name, 8, fired_at);
		// single shot from here on
		continuous = 1'b0;
		wait_busy_low(name, 16);
		drive_lane(lane, 1'b0);
		next_cycle();
		drive_lane(lane, 1'b1);
		watch_no_trigger(name, 8);
		drive_lane(lane, 1'b0);
		compare_bit({name, " busy idle"}, 1'b0, busy);
		check_all_counts(name);
		finish_test(name);
	endtask

	task automatic test_clear_counts();
		int lane;
		clear_counts = 1'b1;
		next_cycle();
		clear_counts = 1'b0;
		for (int ch = 0; ch < channels; ch++) begin
			expected_counts[ch] = '0;
		end
		check_all_counts("clear_counts all");
		// clear lands in the cycle the lane pulse is high
		lane = $urandom % lanes;
		level_in[lane] = 1'b1;
		repeat (3) next_cycle();
		clear_counts = 1'b1;
		next_cycle();
		clear_counts = 1'b0;
		check_all_counts("clear_counts same cycle");
		// lane still counts afterwards
		drive_lane(lane, 1'b0);
		next_cycle();
		drive_lane(lane, 1'b1);
		repeat (5) next_cycle();
		check_all_counts("clear_counts after");
		drive_lane(lane, 1'b0);
		finish_test("clear_counts");
	endtask

	initial begin
		clock = 1'b0;
		randy = 1'b1;
		level_in = '0;
		strobe_in = 1'b0;
		arm = 1'b0;
		continuous = 1'b0;
		enable_mask = '0;
		clear_counts = 1'b0;
		count_select = '0;
		for (int ch = 0; ch < channels; ch++) begin
			expected_counts[ch] = '0;
		end
		void'($urandom(68));
		repeat (3) @(posedge clock);
		#1;
		randy = 1'b0;
		test_reset_state();
		test_level_edges();
		test_narrow_strobes();
		test_single_trigger();
		test_continuous_mode();
		test_clear_counts();
		$display("tests passed %0d failed %0d, assertion failures %0d",
			pass_count, fail_count, DUT.u_asserts.assert_failures);
		if (fail_count == 0 && DUT.u_asserts.assert_failures == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: trigger_front_end.f
+incdir+rtl
rtl/trigger_pkg.sv
rtl/edge_to_pulse.sv
rtl/pulse_catcher.sv
rtl/event_counters.sv
rtl/timestamp_capture.sv
rtl/trigger_control.sv
rtl/trigger_front_end.sv
sim/trigger_front_end_asserts.sv
sim/trigger_front_end_tb.sv

// File: Bender.yml
package:
  name: trigger_front_end

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/trigger_pkg.sv
      - rtl/edge_to_pulse.sv
      - rtl/pulse_catcher.sv
      - rtl/event_counters.sv
      - rtl/timestamp_capture.sv
      - rtl/trigger_control.sv
      - rtl/trigger_front_end.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/trigger_front_end_asserts.sv
      - sim/trigger_front_end_tb.sv
